// File: Bender.yml
package:
  name: cpu_backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_types_pkg.sv
      - logic/wb_bus_pkg.sv
      - logic/alu.sv
      - logic/cpu_ex.sv
      - logic/cpu_ma.sv
      - logic/data_ram.sv
      - logic/cpu_backend.sv
  - target: test
    files:
      - test/cpu_backend_tb.sv

// File: logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu_types_pkg::alu_mode_t alu_mode_i,
    input  cpu_types_pkg::word_t     alu_op1_i,
    input  cpu_types_pkg::word_t     alu_op2_i,
    output cpu_types_pkg::word_t     alu_result_o
);

    logic [4:0] shamt;

    assign shamt = alu_op2_i[4:0];   // rv32 shift amount

    always_comb begin
        case (alu_mode_i)
            cpu_types_pkg::ALU_ADD:  alu_result_o = alu_op1_i + alu_op2_i;
            cpu_types_pkg::ALU_SUB:  alu_result_o = alu_op1_i - alu_op2_i;
            cpu_types_pkg::ALU_AND:  alu_result_o = alu_op1_i & alu_op2_i;
            cpu_types_pkg::ALU_OR:   alu_result_o = alu_op1_i | alu_op2_i;
            cpu_types_pkg::ALU_XOR:  alu_result_o = alu_op1_i ^ alu_op2_i;
            cpu_types_pkg::ALU_SLL:  alu_result_o = alu_op1_i << shamt;
            cpu_types_pkg::ALU_SRL:  alu_result_o = alu_op1_i >> shamt;
            cpu_types_pkg::ALU_SRA: begin
                alu_result_o = $signed(alu_op1_i) >>> shamt;    // keeps sign bit
            end
            cpu_types_pkg::ALU_SLT: begin
                alu_result_o = {31'b0, $signed(alu_op1_i) < $signed(alu_op2_i)};
            end
            cpu_types_pkg::ALU_SLTU: begin
                alu_result_o = {31'b0, alu_op1_i < alu_op2_i};
            end
            default: alu_result_o = '0;
        endcase
    end

endmodule

// File: logic/cpu_backend.sv
`timescale 1ns/100ps

module cpu_backend (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  cpu_types_pkg::ex_op_t  op_i,
    input  logic                   op_valid_i,
    output logic                   op_ready_o,
    output cpu_types_pkg::retire_t retire_o,
    output logic                   retire_valid_o
);

    cpu_types_pkg::ma_op_t ma_op;
    logic                  stall;
    wb_bus_pkg::wb_req_t   bus_req;
    wb_bus_pkg::wb_rsp_t   bus_rsp;

    assign op_ready_o = !stall;     // EX holds while MA waits on the bus

    cpu_ex cpu_ex_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .op_i       (op_i),
        .op_valid_i (op_valid_i),
        .stall_i    (stall),
        .ma_op_o    (ma_op)
    );

    cpu_ma cpu_ma_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ma_op_i        (ma_op),
        .stall_o        (stall),
        .bus_req_o      (bus_req),
        .bus_rsp_i      (bus_rsp),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o)
    );

    data_ram data_ram_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp)
    );

endmodule

// File: logic/cpu_ex.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_ex (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  cpu_types_pkg::ex_op_t op_i,
    input  logic                  op_valid_i,
    input  logic                  stall_i,     // MA still waiting on the bus
    output cpu_types_pkg::ma_op_t ma_op_o
);

    localparam cpu_types_pkg::ma_op_t ma_empty = '{
        pc:       `NOP_PC,
        ir:       `NOP_IR,
        ma_addr:  '0,
        ma_mode:  cpu_types_pkg::MA_NONE,
        ma_size:  cpu_types_pkg::MA_WORD,
        ma_data:  '0,
        wb_src:   cpu_types_pkg::WB_SRC_ALU,
        wb_data:  '0,
        wb_valid: 1'b0
    };

    cpu_types_pkg::word_t  alu_result;
    cpu_types_pkg::ma_op_t ma_next;

    alu alu_i (
        .alu_mode_i   (op_i.alu_mode),
        .alu_op1_i    (op_i.alu_op1),
        .alu_op2_i    (op_i.alu_op2),
        .alu_result_o (alu_result)
    );

    always_comb begin
        ma_next.pc       = op_i.pc;
        ma_next.ir       = op_i.ir;
        ma_next.ma_addr  = alu_result;      // address for loads and stores
        ma_next.ma_mode  = op_i.ma_mode;
        ma_next.ma_size  = op_i.ma_size;
        ma_next.ma_data  = op_i.ma_data;
        ma_next.wb_src   = op_i.wb_src;
        ma_next.wb_data  = (op_i.wb_src == cpu_types_pkg::WB_SRC_ALU) ? alu_result
                                                                       : op_i.wb_data;
        ma_next.wb_valid = op_i.wb_valid;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ma_op_o <= ma_empty;
        end else if (!stall_i) begin
            if (op_valid_i) begin
                ma_op_o <= ma_next;
            end else begin
                ma_op_o <= ma_empty;        // bubble
            end
        end
    end

endmodule

// File: logic/cpu_ma.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_ma (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  cpu_types_pkg::ma_op_t  ma_op_i,
    output logic                   stall_o,
    output wb_bus_pkg::wb_req_t    bus_req_o,
    input  wb_bus_pkg::wb_rsp_t    bus_rsp_i,
    output cpu_types_pkg::retire_t retire_o,
    output logic                   retire_valid_o
);

    logic                   busy;         // slot holds a real instruction
    logic                   mem_access;
    logic [1:0]             lane;
    cpu_types_pkg::word_t   store_data;
    logic [3:0]             store_sel;
    cpu_types_pkg::word_t   shifted;
    cpu_types_pkg::word_t   load_data;
    cpu_types_pkg::retire_t retire_next;

    assign busy       = (ma_op_i.pc != `NOP_PC);
    assign mem_access = (ma_op_i.ma_mode != cpu_types_pkg::MA_NONE);
    assign lane       = ma_op_i.ma_addr[1:0];

    // the register only advances on ack, so a memory op here is always pending
    assign stall_o = mem_access && !bus_rsp_i.ack;

    always_comb begin
        case (ma_op_i.ma_size)
            cpu_types_pkg::MA_BYTE, cpu_types_pkg::MA_BYTE_U: begin
                store_sel  = 4'b0001 << lane;
                store_data = {4{ma_op_i.ma_data[7:0]}};
            end
            cpu_types_pkg::MA_HALF, cpu_types_pkg::MA_HALF_U: begin
                store_sel  = 4'b0011 << {lane[1], 1'b0};
                store_data = {2{ma_op_i.ma_data[15:0]}};
            end
            default: begin
                store_sel  = 4'b1111;
                store_data = ma_op_i.ma_data;
            end
        endcase
    end

    always_comb begin
        bus_req_o.cyc = mem_access;
        bus_req_o.stb = mem_access;
        bus_req_o.we  = (ma_op_i.ma_mode == cpu_types_pkg::MA_STORE);
        bus_req_o.adr = ma_op_i.ma_addr;
        bus_req_o.sel = store_sel;       // slave ignores sel on reads
        bus_req_o.dat = store_data;
    end

    assign shifted = bus_rsp_i.dat >> {lane, 3'b000};   // addressed lane to bit 0

    always_comb begin
        case (ma_op_i.ma_size)
            cpu_types_pkg::MA_BYTE:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            cpu_types_pkg::MA_BYTE_U: load_data = {24'b0, shifted[7:0]};
            cpu_types_pkg::MA_HALF:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            cpu_types_pkg::MA_HALF_U: load_data = {16'b0, shifted[15:0]};
            default:                  load_data = bus_rsp_i.dat;
        endcase
    end

    always_comb begin
        retire_next.pc   = ma_op_i.pc;
        retire_next.rd   = ma_op_i.ir[11:7];
        retire_next.data = (ma_op_i.wb_src == cpu_types_pkg::WB_SRC_MEM) ? load_data
                                                                         : ma_op_i.wb_data;
        retire_next.we   = ma_op_i.wb_valid && (ma_op_i.ma_mode != cpu_types_pkg::MA_STORE);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= busy && !stall_o;   // one pulse per instruction
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy && !stall_o) begin
            retire_o <= retire_next;
        end
    end

endmodule

// File: logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// pc of an empty pipeline slot
`define NOP_PC 32'hffff_ffff

// addi x0, x0, 0
`define NOP_IR 32'h0000_0013

// data memory word address width
`define DMEM_ADDR_BITS 8
`define DMEM_WORDS (1 << `DMEM_ADDR_BITS)

`endif

// File: logic/cpu_types_pkg.sv
package cpu_types_pkg;

    typedef logic [31:0] word_t;     // one data word
    typedef logic [4:0]  regaddr_t;  // register index

    // encodings also used by the test data file
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_mode_t;

    typedef enum logic [1:0] {
        MA_NONE  = 2'd0,
        MA_LOAD  = 2'd1,
        MA_STORE = 2'd2
    } ma_mode_t;

    typedef enum logic [2:0] {
        MA_BYTE   = 3'd0,
        MA_HALF   = 3'd1,
        MA_WORD   = 3'd2,
        MA_BYTE_U = 3'd3,
        MA_HALF_U = 3'd4
    } ma_size_t;

    typedef enum logic [1:0] {
        WB_SRC_ALU  = 2'd0,
        WB_SRC_MEM  = 2'd1,
        WB_SRC_DATA = 2'd2    // link value or upper immediate
    } wb_src_t;

    // decoded operation entering execute
    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;      // store data
        wb_src_t   wb_src;
        word_t     wb_data;
        logic      wb_valid;
    } ex_op_t;

    // EX/MA pipeline register
    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     ma_addr;      // alu result
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;
        wb_src_t   wb_src;
        word_t     wb_data;      // alu result or supplied value
        logic      wb_valid;
    } ma_op_t;

    typedef struct packed {
        word_t     pc;
        regaddr_t  rd;
        word_t     data;
        logic      we;           // low for stores
    } retire_t;

endpackage

// File: logic/data_ram.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module data_ram (
    input  logic                clk_i,
    input  logic                reset_i,
    input  wb_bus_pkg::wb_req_t bus_req_i,
    output wb_bus_pkg::wb_rsp_t bus_rsp_o
);

    logic [31:0]                mem [`DMEM_WORDS];
    logic [`DMEM_ADDR_BITS-1:0] word_addr;
    logic                       access;
    logic                       ack_q;
    logic [31:0]                rdata_q;

    assign word_addr = bus_req_i.adr[`DMEM_ADDR_BITS+1:2];   // drop byte offset
    assign access    = bus_req_i.cyc && bus_req_i.stb;

    // ack one cycle after stb, then low for a cycle so a new strobe is seen fresh
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access && !ack_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && !ack_q) begin
            rdata_q <= mem[word_addr];      // returned alongside ack
        end
        if (access && ack_q && bus_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req_i.sel[b]) begin
                    mem[word_addr][b*8 +: 8] <= bus_req_i.dat[b*8 +: 8];
                end
            end
        end
    end

    assign bus_rsp_o.ack = ack_q;
    assign bus_rsp_o.dat = rdata_q;

endmodule

// File: logic/wb_bus_pkg.sv
package wb_bus_pkg;

    typedef logic [31:0] wb_data_t;
    typedef logic [31:0] wb_addr_t;
    typedef logic [3:0]  wb_sel_t;   // one bit per byte lane

    // master to slave request
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;       // byte address
        wb_sel_t  sel;
        wb_data_t dat;       // write data
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;
        wb_data_t dat;       // read data valid with ack
    } wb_rsp_t;

endpackage

// File: test/backend_tests.txt
# pc ir alu_mode op1 op2 ma_mode ma_size ma_data wb_src wb_data wb_valid exp_data exp_we
# all hex, mode fields use the enum codes of cpu_types_pkg
00000100 00000093 0 00000005 00000007 0 2 00000000 0 00000000 1 0000000c 1
00000104 00000113 1 00000003 00000005 0 2 00000000 0 00000000 1 fffffffe 1
00000108 00000193 2 f0f0f0f0 ff00ff00 0 2 00000000 0 00000000 1 f000f000 1
0000010c 00000213 3 f0f0f0f0 0f000f00 0 2 00000000 0 00000000 1 fff0fff0 1
00000110 00000293 4 aaaa5555 ffff0000 0 2 00000000 0 00000000 1 55555555 1
00000114 00000313 5 00000001 00000024 0 2 00000000 0 00000000 1 00000010 1
00000118 00000393 6 80000000 00000004 0 2 00000000 0 00000000 1 08000000 1
0000011c 00000413 7 80000000 00000004 0 2 00000000 0 00000000 1 f8000000 1
00000120 00000493 8 ffffffff 00000001 0 2 00000000 0 00000000 1 00000001 1
00000124 00000513 9 ffffffff 00000001 0 2 00000000 0 00000000 1 00000000 1
00000128 00000593 8 00000001 ffffffff 0 2 00000000 0 00000000 1 00000000 1
0000012c 00000613 9 00000001 ffffffff 0 2 00000000 0 00000000 1 00000001 1
00000130 000006b7 0 00000000 00000000 0 2 00000000 2 12345000 1 12345000 1
00000134 0000076f 0 00000000 00000000 0 2 00000000 2 00000138 1 00000138 1
00000138 00812023 0 00000040 00000000 2 2 deadbeef 0 00000000 0 00000040 0
0000013c 04002503 0 00000040 00000000 1 2 00000000 1 00000000 1 deadbeef 1
00000140 00912223 0 0000007c 00000004 2 2 11223344 0 00000000 1 00000080 0
00000144 000000a3 0 00000080 00000001 2 0 000000aa 0 00000000 0 00000081 0
00000148 00001123 0 00000080 00000002 2 1 00008765 0 00000000 0 00000082 0
0000014c 00002583 0 00000080 00000000 1 2 00000000 1 00000000 1 8765aa44 1
00000150 00000603 0 00000080 00000000 1 0 00000000 1 00000000 1 00000044 1
00000154 00000683 0 00000080 00000001 1 0 00000000 1 00000000 1 ffffffaa 1
00000158 00004703 0 00000080 00000001 1 3 00000000 1 00000000 1 000000aa 1
0000015c 00000783 0 00000080 00000002 1 0 00000000 1 00000000 1 00000065 1
00000160 00000803 0 00000080 00000003 1 0 00000000 1 00000000 1 ffffff87 1
00000164 00004883 0 00000080 00000003 1 3 00000000 1 00000000 1 00000087 1
00000168 00001903 0 00000080 00000000 1 1 00000000 1 00000000 1 ffffaa44 1
0000016c 00005983 0 00000080 00000000 1 4 00000000 1 00000000 1 0000aa44 1
00000170 00001a03 0 00000080 00000002 1 1 00000000 1 00000000 1 ffff8765 1
00000174 00005a83 0 00000080 00000002 1 4 00000000 1 00000000 1 00008765 1
00000178 00002023 0 000000c0 00000000 2 2 00000000 0 00000000 0 000000c0 0
0000017c 000001a3 0 000000c0 00000003 2 0 0000007f 0 00000000 0 000000c3 0
00000180 00001023 0 000000c0 00000000 2 1 00001234 0 00000000 0 000000c0 0
00000184 00002b03 0 000000c0 00000000 1 2 00000000 1 00000000 1 7f001234 1
00000188 00001b83 0 000000c0 00000002 1 1 00000000 1 00000000 1 00007f00 1
0000018c 00000c13 0 00000003 00000004 0 2 00000000 0 00000000 1 00000007 1

// File: test/cpu_backend_tb.sv
`timescale 1ns/100ps

module cpu_backend_tb;

    localparam int          ready_timeout  = 20;             // cycles per wait
    localparam int          retire_timeout = 40;
    localparam logic [31:0] lfsr_taps      = 32'h8020_0003;

    logic                   clk_i;
    logic                   reset_i;
    cpu_types_pkg::ex_op_t  op_i;
    logic                   op_valid_i;
    logic                   op_ready_o;
    cpu_types_pkg::retire_t retire_o;
    logic                   retire_valid_o;

    cpu_types_pkg::ex_op_t  ops [$];
    cpu_types_pkg::retire_t file_retires [$];
    cpu_types_pkg::retire_t pending [$];          // accepted but not yet retired
    logic [31:0]            lfsr;

    cpu_backend cpu_backend_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .op_i           (op_i),
        .op_valid_i     (op_valid_i),
        .op_ready_o     (op_ready_o),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken from the lsb
    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | lfsr[0];
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_tests();
        int                     fd;
        int                     n;
        string                  line;
        logic [31:0]            f [13];
        cpu_types_pkg::ex_op_t  op;
        cpu_types_pkg::retire_t exp;
        fd = $fopen("test/backend_tests.txt", "r");
        if (fd == 0) begin
            fail_run("could not open test/backend_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                           // comment or blank
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n != 13) begin
                fail_run("a line of test/backend_tests.txt has the wrong number of fields");
            end
            op.pc       = f[0];
            op.ir       = f[1];
            op.alu_mode = cpu_types_pkg::alu_mode_t'(f[2][3:0]);
            op.alu_op1  = f[3];
            op.alu_op2  = f[4];
            op.ma_mode  = cpu_types_pkg::ma_mode_t'(f[5][1:0]);
            op.ma_size  = cpu_types_pkg::ma_size_t'(f[6][2:0]);
            op.ma_data  = f[7];
            op.wb_src   = cpu_types_pkg::wb_src_t'(f[8][1:0]);
            op.wb_data  = f[9];
            op.wb_valid = f[10][0];
            exp.pc      = f[0];
            exp.rd      = f[1][11:7];               // rd field of the instruction
            exp.data    = f[11];
            exp.we      = f[12][0];
            ops.push_back(op);
            file_retires.push_back(exp);
        end
        $fclose(fd);
    endtask

    // retire checker sampled mid-cycle
    always @(negedge clk_i) begin
        cpu_types_pkg::retire_t exp;
        if (!reset_i) begin
            if (retire_valid_o) begin
                if (pending.size() == 0) begin
                    fail_run("a retire appeared with no accepted operation outstanding");
                end
                exp = pending.pop_front();
                check_value("retire_o.pc", retire_o.pc, exp.pc);
                check_value("retire_o.rd", retire_o.rd, exp.rd);
                check_value("retire_o.data", retire_o.data, exp.data);
                check_value("retire_o.we", retire_o.we, exp.we);
            end
        end
    end

    initial begin
        int gap;
        int waited;
        clk_i      = 1'b0;
        reset_i    = 1'b1;
        op_valid_i = 1'b0;
        op_i       = '0;
        lfsr       = 32'ha504;
        load_tests();
        repeat (5) @(posedge clk_i);
        #0.5 reset_i = 1'b0;
        check_value("op_ready_o", op_ready_o, 1'b1);
        check_value("retire_valid_o", retire_valid_o, 1'b0);

        foreach (ops[i]) begin
            random_bits(2, gap);                    // 0 to 3 idle cycles
            repeat (gap) begin
                @(posedge clk_i);
                #0.5;
            end
            op_i       = ops[i];
            op_valid_i = 1'b1;
            waited     = 0;
            while (!op_ready_o) begin
                @(posedge clk_i);
                #0.5;
                waited++;
                if (waited > ready_timeout) begin
                    fail_run("timed out waiting for op_ready_o to accept an operation");
                end
            end
            pending.push_back(file_retires[i]);     // taken at the coming edge
            @(posedge clk_i);
            #0.5;
            // a load or store now waits in MA for its ack
            check_value("op_ready_o", op_ready_o,
                        ops[i].ma_mode == cpu_types_pkg::MA_NONE);
            op_valid_i = 1'b0;
            op_i       = '0;
        end

        waited = 0;
        while (pending.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > retire_timeout) begin
                fail_run("timed out waiting for the last operation to retire");
            end
        end
        repeat (3) @(posedge clk_i);                // room for a stray duplicate
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/wb_bus_pkg.sv
logic/alu.sv
logic/cpu_ex.sv
logic/cpu_ma.sv
logic/data_ram.sv
logic/cpu_backend.sv
test/cpu_backend_tb.sv
